/* Makefile */
VERILATOR := verilator
TOP       := cpu_mem_wb_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
LINT_TOP  := cpu_mem_wb
OBJ_DIR   := obj_dir
PASS_TEXT := No errors
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/common_pkg.sv */
package common_pkg;

    localparam int unsigned XLEN = 32;       // integer register width

    // basic machine types
    typedef logic [XLEN-1:0] word_t;         // data, address or instruction
    typedef logic [4:0]      regaddr_t;      // register number
    typedef logic [1:0]      ma_align_t;     // byte offset inside a word

    // memory access mode
    typedef enum logic [1:0] {
        MA_X     = 2'b00,                    // no memory access
        MA_LOAD  = 2'b01,
        MA_STORE = 2'b10
    } ma_mode_t;

    // memory access size
    typedef enum logic [1:0] {
        MA_SIZE_B = 2'b00,                   // byte
        MA_SIZE_H = 2'b01,                   // halfword
        MA_SIZE_W = 2'b10                    // word
    } ma_size_t;

    // where the register file write comes from
    typedef enum logic [1:0] {
        WB_SRC_ALU = 2'b00,
        WB_SRC_PC  = 2'b01,                  // link address
        WB_SRC_MEM = 2'b10                   // load data, late
    } wb_src_t;

    // instruction fields used by the back end
    localparam int unsigned RD_LSB            = 7;
    localparam int unsigned RD_MSB            = 11;
    localparam int unsigned LOAD_UNSIGNED_BIT = 14;  // funct3[2] of loads

    // bubble contents
    // a pc that can never be fetched marks an empty stage
    localparam word_t    NOP_PC       = 32'hffff_ffff;
    localparam word_t    NOP_IR       = 32'h0000_0013;  // addi x0,x0,0
    localparam ma_size_t NOP_MA_SIZE  = MA_SIZE_W;
    localparam logic     NOP_WB_VALID = 1'b0;

endpackage

/* rtl/cpu_dmem.sv */
`timescale 1ns/100ps

module cpu_dmem #(
    parameter int unsigned DMEM_WORDS = 1024   // depth, power of two
) (
    input  logic                    clk_i,
    input  pipeline_pkg::dmem_req_t dmem_req_i,
    output common_pkg::word_t       read_data_o  // one cycle after the request
);

    import common_pkg::*;

    localparam int unsigned INDEX_BITS = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t                 mem [DMEM_WORDS];
    logic [INDEX_BITS-1:0] index;

    assign index = dmem_req_i.addr[INDEX_BITS+1:2];  // byte offset dropped

    // byte lane writes
    always_ff @(posedge clk_i) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (dmem_req_i.write_mask[lane]) begin
                mem[index][8*lane +: 8] <= dmem_req_i.write_data[8*lane +: 8];
            end
        end
    end

    // registered read, old word on a same cycle write
    always_ff @(posedge clk_i) begin
        read_data_o <= mem[index];
    end

endmodule

/* rtl/cpu_ma.sv */
`timescale 1ns/100ps

module cpu_ma (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  pipeline_pkg::ma_req_t  req_i,      // from execute
    output pipeline_pkg::dmem_req_t dmem_req_o,
    output pipeline_pkg::ma_fwd_t  fwd_o,      // same cycle view
    output pipeline_pkg::ma_wb_t   ma_wb_o     // to write-back
);

    import common_pkg::*;
    import pipeline_pkg::*;

    ma_align_t align;
    logic      is_store;
    logic      is_load;

    assign align    = req_i.ma_addr[1:0];
    assign is_store = (req_i.ma_mode == MA_STORE);
    assign is_load  = (req_i.ma_mode == MA_LOAD);

    // memory request
    always_comb begin
        dmem_req_o.addr       = {req_i.ma_addr[XLEN-1:2], 2'b00};
        dmem_req_o.write_data = req_i.ma_data << {align, 3'b000};  // move to byte lane
        dmem_req_o.write_mask = 4'b0000;

        if (is_store) begin
            case (req_i.ma_size)
                MA_SIZE_B: begin
                    dmem_req_o.write_mask = 4'b0001 << align;
                end
                MA_SIZE_H: begin
                    if (!align[0]) begin                 // lanes 0-1 or 2-3 only
                        dmem_req_o.write_mask = 4'b0011 << align;
                    end
                end
                MA_SIZE_W: begin
                    if (align == 2'b00) begin
                        dmem_req_o.write_mask = 4'b1111;
                    end
                end
                default: begin
                    dmem_req_o.write_mask = 4'b0000;
                end
            endcase
        end
    end

    // forwarding view, no register in between
    always_comb begin
        fwd_o.wb_addr  = req_i.ir[RD_MSB:RD_LSB];
        fwd_o.wb_data  = req_i.wb_data;
        fwd_o.wb_ready = (req_i.wb_src != WB_SRC_MEM);    // loads resolve in wb
        fwd_o.wb_valid = req_i.wb_valid;
        fwd_o.empty    = (req_i.pc == NOP_PC);
    end

    // pipeline register towards write-back
    always_ff @(posedge clk_i) begin
        ma_wb_o.pc           <= req_i.pc;
        ma_wb_o.ir           <= req_i.ir;
        ma_wb_o.load         <= is_load;
        ma_wb_o.ma_alignment <= align;
        ma_wb_o.wb_data      <= req_i.wb_data;
        ma_wb_o.wb_valid     <= req_i.wb_valid;

        if (req_i.ma_mode == MA_X) begin
            ma_wb_o.ma_size <= MA_SIZE_W;                // no access, keep word
        end else begin
            ma_wb_o.ma_size <= req_i.ma_size;
        end

        if (reset_i) begin
            ma_wb_o.pc       <= NOP_PC;
            ma_wb_o.ir       <= NOP_IR;
            ma_wb_o.load     <= 1'b0;
            ma_wb_o.ma_size  <= NOP_MA_SIZE;
            ma_wb_o.wb_valid <= NOP_WB_VALID;
        end
    end

endmodule

/* rtl/cpu_mem_wb.sv */
`timescale 1ns/100ps

module cpu_mem_wb #(
    parameter int unsigned DMEM_WORDS = 1024   // data memory depth in words
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  pipeline_pkg::ma_req_t   req_i,      // from execute
    output pipeline_pkg::ma_fwd_t   fwd_o,      // to hazard and forwarding logic
    output pipeline_pkg::rf_write_t rf_write_o  // to register file
);

    import common_pkg::*;
    import pipeline_pkg::*;

    dmem_req_t dmem_req;
    ma_wb_t    ma_wb;
    word_t     read_data;   // lines up with ma_wb

    cpu_ma i_cpu_ma (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .dmem_req_o (dmem_req),
        .fwd_o      (fwd_o),
        .ma_wb_o    (ma_wb)
    );

    cpu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_cpu_dmem (
        .clk_i       (clk_i),
        .dmem_req_i  (dmem_req),
        .read_data_o (read_data)
    );

    cpu_wb i_cpu_wb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ma_wb_i     (ma_wb),
        .read_data_i (read_data),
        .rf_write_o  (rf_write_o)
    );

endmodule

/* rtl/cpu_wb.sv */
`timescale 1ns/100ps

module cpu_wb (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  pipeline_pkg::ma_wb_t    ma_wb_i,      // from memory access
    input  common_pkg::word_t       read_data_i,  // data memory read port
    output pipeline_pkg::rf_write_t rf_write_o
);

    import common_pkg::*;

    word_t    lane_data;       // read word with the addressed byte at bit 0
    word_t    load_data;
    logic     load_unsigned;
    regaddr_t rd;
    logic     write_en;

    assign rd            = ma_wb_i.ir[RD_MSB:RD_LSB];
    assign load_unsigned = ma_wb_i.ir[LOAD_UNSIGNED_BIT];  // lbu / lhu
    assign write_en      = (ma_wb_i.wb_valid || ma_wb_i.load) && (rd != '0);

    // load alignment and extension
    always_comb begin
        lane_data = read_data_i >> {ma_wb_i.ma_alignment, 3'b000};

        case (ma_wb_i.ma_size)
            MA_SIZE_B: begin
                if (load_unsigned) begin
                    load_data = {24'b0, lane_data[7:0]};
                end else begin
                    load_data = {{24{lane_data[7]}}, lane_data[7:0]};
                end
            end
            MA_SIZE_H: begin
                if (load_unsigned) begin
                    load_data = {16'b0, lane_data[15:0]};
                end else begin
                    load_data = {{16{lane_data[15]}}, lane_data[15:0]};
                end
            end
            default: begin
                load_data = lane_data;                  // word, alignment 0
            end
        endcase
    end

    // register file write
    always_ff @(posedge clk_i) begin
        rf_write_o.addr  <= rd;
        rf_write_o.valid <= write_en;                   // x0 never written

        if (ma_wb_i.load) begin
            rf_write_o.data <= load_data;
        end else begin
            rf_write_o.data <= ma_wb_i.wb_data;
        end

        if (reset_i) begin
            rf_write_o.valid <= 1'b0;
        end
    end

endmodule

/* rtl/pipeline_pkg.sv */
package pipeline_pkg;

    import common_pkg::*;

    // execute to memory access
    typedef struct packed {
        word_t    pc;
        word_t    ir;
        word_t    ma_addr;                   // byte address of the access
        ma_mode_t ma_mode;
        ma_size_t ma_size;
        word_t    ma_data;                   // store data, lane 0 aligned
        wb_src_t  wb_src;
        word_t    wb_data;                   // alu result or link address
        logic     wb_valid;
    } ma_req_t;

    // memory access to write-back register
    typedef struct packed {
        word_t     pc;
        word_t     ir;
        logic      load;
        ma_size_t  ma_size;
        ma_align_t ma_alignment;
        word_t     wb_data;
        logic      wb_valid;
    } ma_wb_t;

    // what the memory access stage holds, for forwarding and hazards
    typedef struct packed {
        regaddr_t wb_addr;
        word_t    wb_data;
        logic     wb_ready;                  // data already known
        logic     wb_valid;
        logic     empty;
    } ma_fwd_t;

    // register file write port
    typedef struct packed {
        regaddr_t addr;
        word_t    data;
        logic     valid;
    } rf_write_t;

    // data memory request
    typedef struct packed {
        word_t      addr;                    // word aligned
        word_t      write_data;
        logic [3:0] write_mask;              // one bit per byte lane
    } dmem_req_t;

endpackage

/* tests/cpu_mem_wb_tb.sv */
`timescale 1ns/100ps

module cpu_mem_wb_tb;

    import common_pkg::*;
    import pipeline_pkg::*;

    localparam int CYCLE_LIMIT = 400;           // about 170 cycles of tests plus margin

    logic      clk_i;
    logic      reset_i;
    ma_req_t   req_i;
    ma_fwd_t   fwd_o;
    rf_write_t rf_write_o;

    logic [7:0] shadow [256];                   // first 64 words, byte wide
    rf_write_t  expected_q [$];                 // at most two in flight
    string      name_q [$];
    int         seed = 95482;
    int         cycle_count = 0;

    cpu_mem_wb #(
        .DMEM_WORDS (1024)
    ) i_cpu_mem_wb (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .fwd_o      (fwd_o),
        .rf_write_o (rf_write_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic ma_req_t make_req(input ma_mode_t mode, input ma_size_t size,
                                         input word_t addr, input word_t data,
                                         input wb_src_t src, input regaddr_t rd,
                                         input logic ld_unsigned, input word_t wb_data,
                                         input logic wb_valid);
        ma_req_t req;
        req          = '0;
        req.pc       = 32'h0000_0100;
        req.ir[11:7] = rd;
        req.ir[14]   = ld_unsigned;
        case (mode)
            MA_LOAD:  req.ir[6:0] = 7'h03;
            MA_STORE: req.ir[6:0] = 7'h23;
            default:  req.ir[6:0] = 7'h13;
        endcase
        req.ma_mode  = mode;
        req.ma_size  = size;
        req.ma_addr  = addr;
        req.ma_data  = data;
        req.wb_src   = src;
        req.wb_data  = wb_data;
        req.wb_valid = wb_valid;
        return req;
    endfunction

    function automatic ma_req_t bubble();
        ma_req_t req;
        req         = '0;
        req.pc      = NOP_PC;
        req.ir      = NOP_IR;
        req.ma_size = MA_SIZE_W;
        return req;
    endfunction

    function automatic word_t random_addr(input logic [1:0] align);
        word_t r;
        r = $random(seed);
        return {24'b0, r[5:0], align};          // first 64 words only
    endfunction

    // extended lane as a load of this size and signedness sees it
    function automatic word_t load_value(input ma_req_t req);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = req.ma_addr[7:0];
        b = shadow[a];
        h = {shadow[a + 8'd1], shadow[a]};
        case (req.ma_size)
            MA_SIZE_B: return req.ir[14] ? {24'b0, b} : {{24{b[7]}}, b};
            MA_SIZE_H: return req.ir[14] ? {16'b0, h} : {{16{h[15]}}, h};
            default:   return {shadow[a + 8'd3], shadow[a + 8'd2], h};
        endcase
    endfunction

    task automatic store_shadow(input ma_req_t req);
        logic [7:0] a;
        a = req.ma_addr[7:0];
        case (req.ma_size)
            MA_SIZE_B: shadow[a] = req.ma_data[7:0];
            MA_SIZE_H: begin
                if (!a[0]) begin                // lanes 0-1 or 2-3
                    shadow[a]         = req.ma_data[7:0];
                    shadow[a + 8'd1]  = req.ma_data[15:8];
                end
            end
            default: begin
                if (a[1:0] == 2'b00) begin
                    shadow[a]        = req.ma_data[7:0];
                    shadow[a + 8'd1] = req.ma_data[15:8];
                    shadow[a + 8'd2] = req.ma_data[23:16];
                    shadow[a + 8'd3] = req.ma_data[31:24];
                end
            end
        endcase
    endtask

    task automatic check_rf_write();
        rf_write_t expected;
        string     name;
        expected = expected_q.pop_front();
        name     = name_q.pop_front();
        check_value({name, " valid"}, {31'b0, expected.valid}, {31'b0, rf_write_o.valid});
        if (expected.valid) begin
            check_value({name, " addr"}, {27'b0, expected.addr}, {27'b0, rf_write_o.addr});
            check_value({name, " data"}, expected.data, rf_write_o.data);
        end
    endtask

    task automatic check_fwd(input string name, input ma_req_t req);
        check_value({name, " fwd addr"}, {27'b0, req.ir[11:7]}, {27'b0, fwd_o.wb_addr});
        check_value({name, " fwd data"}, req.wb_data, fwd_o.wb_data);
        check_value({name, " fwd valid"}, {31'b0, req.wb_valid}, {31'b0, fwd_o.wb_valid});
        check_value({name, " fwd ready"}, {31'b0, req.wb_src != WB_SRC_MEM},
                    {31'b0, fwd_o.wb_ready});
        check_value({name, " fwd empty"}, {31'b0, req.pc == NOP_PC}, {31'b0, fwd_o.empty});
    endtask

    // one request per cycle, result checked two cycles later
    task automatic apply(input string name, input ma_req_t req);
        rf_write_t expected;
        @(negedge clk_i);
        if (expected_q.size() == 2) begin
            check_rf_write();
        end
        expected.addr  = req.ir[11:7];
        expected.valid = (req.wb_valid || req.ma_mode == MA_LOAD) && (req.ir[11:7] != 5'd0);
        expected.data  = (req.ma_mode == MA_LOAD) ? load_value(req) : req.wb_data;
        if (req.ma_mode == MA_STORE) begin
            store_shadow(req);
        end
        req_i = req;
        expected_q.push_back(expected);
        name_q.push_back(name);
        #1;
        check_fwd(name, req);
    endtask

    task automatic store_then_check(input string name, input ma_size_t size,
                                    input logic [1:0] align);
        word_t addr;
        word_t data;
        addr = random_addr(align);
        data = $random(seed);
        apply(name, make_req(MA_STORE, size, addr, data, WB_SRC_ALU, 5'd3, 1'b0, '0, 1'b0));
        apply({name, " readback"}, make_req(MA_LOAD, MA_SIZE_W, {addr[31:2], 2'b00}, '0,
                                            WB_SRC_MEM, 5'd5, 1'b0, '0, 1'b0));
    endtask

    initial begin
        clk_i   = 1'b0;
        reset_i = 1'b1;
        // live write during reset, only the stage register reset hides it
        req_i   = make_req(MA_X, MA_SIZE_W, '0, '0, WB_SRC_ALU, 5'd4, 1'b0,
                           32'h1234_5678, 1'b1);
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        req_i   = bubble();
        @(negedge clk_i);
        check_value("reset valid", 32'd0, {31'b0, rf_write_o.valid});
        check_value("reset empty", 32'd1, {31'b0, fwd_o.empty});

        for (int w = 0; w < 64; w++) begin      // known contents before any load
            apply("init", make_req(MA_STORE, MA_SIZE_W, word_t'(w * 4), $random(seed),
                                   WB_SRC_ALU, 5'd0, 1'b0, '0, 1'b0));
        end

        apply("alu pass", make_req(MA_X, MA_SIZE_B, '0, '0, WB_SRC_ALU, 5'd7, 1'b0,
                                   $random(seed), 1'b1));
        apply("alu pass", make_req(MA_X, MA_SIZE_H, '0, '0, WB_SRC_ALU, 5'd31, 1'b0,
                                   $random(seed), 1'b1));
        apply("link pass", make_req(MA_X, MA_SIZE_W, '0, '0, WB_SRC_PC, 5'd1, 1'b0,
                                    $random(seed), 1'b1));
        apply("alu x0", make_req(MA_X, MA_SIZE_W, '0, '0, WB_SRC_ALU, 5'd0, 1'b0,
                                 $random(seed), 1'b1));
        apply("alu no write", make_req(MA_X, MA_SIZE_W, '0, '0, WB_SRC_ALU, 5'd9, 1'b0,
                                       $random(seed), 1'b0));
        apply("bubble", bubble());

        for (int rep = 0; rep < 3; rep++) begin
            for (int a = 0; a < 4; a++) begin
                store_then_check("store byte", MA_SIZE_B, 2'(a));
            end
            store_then_check("store half", MA_SIZE_H, 2'd0);
            store_then_check("store half", MA_SIZE_H, 2'd2);
            store_then_check("store word", MA_SIZE_W, 2'd0);
        end

        for (int rep = 0; rep < 2; rep++) begin
            for (int u = 0; u < 2; u++) begin
                for (int a = 0; a < 4; a++) begin
                    apply("load byte", make_req(MA_LOAD, MA_SIZE_B, random_addr(2'(a)), '0,
                                                WB_SRC_MEM, 5'(a * 7 + u + 1), 1'(u), '0,
                                                1'b0));
                end
                apply("load half", make_req(MA_LOAD, MA_SIZE_H, random_addr(2'd0), '0,
                                            WB_SRC_MEM, 5'd12, 1'(u), '0, 1'b0));
                apply("load half", make_req(MA_LOAD, MA_SIZE_H, random_addr(2'd2), '0,
                                            WB_SRC_MEM, 5'd13, 1'(u), '0, 1'b0));
            end
        end

        store_then_check("misaligned half", MA_SIZE_H, 2'd1);
        store_then_check("misaligned half", MA_SIZE_H, 2'd3);
        for (int a = 1; a < 4; a++) begin
            store_then_check("misaligned word", MA_SIZE_W, 2'(a));
        end

        apply("drain", bubble());               // flush the last two results
        apply("drain", bubble());

        $display("No errors");
        $finish;
    end

endmodule

/* verilog.f */
rtl/common_pkg.sv
rtl/pipeline_pkg.sv
rtl/cpu_ma.sv
rtl/cpu_dmem.sv
rtl/cpu_wb.sv
rtl/cpu_mem_wb.sv
tests/cpu_mem_wb_tb.sv
